/* hw/erx_pkg.sv */
`default_nettype none

package erx_pkg;

   // ##########################################################################
   // Packet layout and field widths
   // ##########################################################################

   // Field order from the top: write, datamode, ctrlmode, dstaddr, data, srcaddr
   typedef logic [103:0] emesh_packet_t;
   typedef logic [31:0]  addr_t;
   typedef logic [31:0]  data_t;
   typedef logic [11:0]  link_id_t;
   typedef logic [3:0]   group_t;

   // Register groups in address bits 19..16
   localparam group_t GROUP_RR  = 4'hD;
   localparam group_t GROUP_REG = 4'hF;

   // Engine register offsets, low address bits
   localparam logic [15:0] DMA_REG_ADDR  = 16'h0000;
   localparam logic [15:0] DMA_REG_COUNT = 16'h0004;
   localparam logic [15:0] DMA_REG_GO    = 16'h0008;

   // ##########################################################################
   // Field extraction
   // ##########################################################################

   function automatic logic pkt_write(input emesh_packet_t pkt);
      return pkt[103];
   endfunction

   function automatic addr_t pkt_dstaddr(input emesh_packet_t pkt);
      return pkt[95:64];
   endfunction

   function automatic data_t pkt_data(input emesh_packet_t pkt);
      return pkt[63:32];
   endfunction

   function automatic addr_t pkt_srcaddr(input emesh_packet_t pkt);
      return pkt[31:0];
   endfunction

   // Read-request engine states
   typedef enum logic {
      IDLE,
      ISSUE
   } dma_state_t;

endpackage

`default_nettype wire

/* hw/erx_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module erx_arbiter import erx_pkg::*; #(
   parameter link_id_t LINK_ID = 12'h800
) (
   // From the address unit
   input  wire           erx_access,
   input  emesh_packet_t erx_packet,
   output logic          rx_wr_wait,
   output logic          rx_rd_wait,
   // Register readback from the transmit side
   input  wire           ecfg_access,
   input  emesh_packet_t ecfg_packet,
   output logic          ecfg_wait,
   // From the read-request engine
   input  wire           edma_access,
   input  emesh_packet_t edma_packet,
   output logic          edma_wait,
   // Buffer inputs
   output logic          wr_access,
   output emesh_packet_t wr_packet,
   input  wire           wr_wait,
   output logic          rd_access,
   output emesh_packet_t rd_packet,
   input  wire           rd_wait,
   output logic          rr_access,
   output emesh_packet_t rr_packet,
   input  wire           rr_wait,
   // Engine register port, no wait
   output logic          cfg_access,
   output emesh_packet_t cfg_packet
);

   // ##########################################################################
   // Decode
   // ##########################################################################

   addr_t erx_dstaddr;
   logic  erx_write;
   logic  erx_read;
   logic  is_own;
   logic  is_rr_group;
   logic  to_rr;
   logic  to_cfg;
   logic  to_wr;
   logic  to_rd;

   assign erx_dstaddr = pkt_dstaddr(erx_packet);
   assign erx_write   = pkt_write(erx_packet);
   assign erx_read    = erx_access & ~erx_write;

   // Own link when the top address bits match
   assign is_own      = (erx_dstaddr[31:20] == LINK_ID);
   assign is_rr_group = (erx_dstaddr[19:16] == GROUP_RR);

   // One path per packet, checked in this order
   assign to_rr  = erx_access & is_own & is_rr_group;
   assign to_cfg = erx_access & is_own & ~is_rr_group & erx_write;
   assign to_wr  = erx_access & ~is_own & erx_write;
   assign to_rd  = erx_read & ~(is_own & is_rr_group);

   // ##########################################################################
   // Waits
   // ##########################################################################

   // Write-side traffic stalls on either buffer or on ecfg
   assign rx_wr_wait = ecfg_access | wr_wait | rr_wait;
   assign rx_rd_wait = rd_wait;
   assign ecfg_wait  = rr_wait;
   // Any erx read holds off the engine
   assign edma_wait  = rd_wait | erx_read;

   // ##########################################################################
   // Path outputs
   // ##########################################################################

   // Write-side paths only fire when the source sees its wait low
   assign wr_access  = to_wr & ~rx_wr_wait;
   assign wr_packet  = erx_packet;
   assign cfg_access = to_cfg & ~rx_wr_wait;
   assign cfg_packet = erx_packet;

   // Response path, ecfg first
   assign rr_access = ecfg_access | (to_rr & ~rx_wr_wait);
   assign rr_packet = ecfg_access ? ecfg_packet : erx_packet;

   // Read path, erx read before the engine
   assign rd_access = to_rd | (edma_access & ~erx_read);
   assign rd_packet = erx_read ? erx_packet : edma_packet;

endmodule

`default_nettype wire

/* hw/erx_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module erx_fifo import erx_pkg::*; #(
   parameter int FIFO_DEPTH = 4
) (
   input  wire           clk,
   input  wire           arst_n,
   // Write side
   input  wire           in_access,
   input  emesh_packet_t in_packet,
   output logic          in_wait,
   // Read side
   output logic          out_access,
   output emesh_packet_t out_packet,
   input  wire           out_wait
);

   localparam int PTR_W = $clog2(FIFO_DEPTH);
   localparam int CNT_W = PTR_W + 1;

   // Packet storage
   emesh_packet_t mem [FIFO_DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic [CNT_W-1:0] count_next;
   logic             full_q;
   logic             push;
   logic             pop;

   // Transfers on each side
   assign push = in_access & ~in_wait;
   assign pop  = out_access & ~out_wait;

   always_comb begin
      count_next = count;
      if (push && !pop) begin
         count_next = count + 1'b1;
      end else if (pop && !push) begin
         count_next = count - 1'b1;
      end
   end

   // ##########################################################################
   // Pointers and occupancy
   // ##########################################################################

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         full_q <= 1'b0;
      end else begin
         if (push) begin
            // Wraps because the depth is a power of two
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count  <= count_next;
         full_q <= (count_next == CNT_W'(FIFO_DEPTH));
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= in_packet;
      end
   end

   // Full flag straight from a flop
   assign in_wait    = full_q;
   // Head stays put until popped
   assign out_access = (count != '0);
   assign out_packet = mem[rd_ptr];

endmodule

`default_nettype wire

/* hw/erx_dma.sv */
`timescale 1ns/1ps
`default_nettype none

module erx_dma import erx_pkg::*; #(
   parameter link_id_t LINK_ID = 12'h800
) (
   input  wire           clk,
   input  wire           arst_n,
   // Register writes from the arbiter
   input  wire           cfg_access,
   input  emesh_packet_t cfg_packet,
   // Read requests out
   output logic          edma_access,
   output emesh_packet_t edma_packet,
   input  wire           edma_wait
);

   dma_state_t state;

   addr_t cfg_addr;
   addr_t reg_start;
   data_t reg_count;
   addr_t cur_addr;
   data_t remaining;
   data_t issue_idx;
   logic  reg_hit;
   logic  go_hit;
   logic  accept;
   addr_t req_srcaddr;

   // ##########################################################################
   // Register decode
   // ##########################################################################

   assign cfg_addr = pkt_dstaddr(cfg_packet);
   assign reg_hit  = cfg_access & (cfg_addr[19:16] == GROUP_REG);
   assign go_hit   = reg_hit & (cfg_addr[15:0] == DMA_REG_GO);
   assign accept   = edma_access & ~edma_wait;

   // Programmed start and count
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         reg_start <= '0;
         reg_count <= '0;
      end else if (reg_hit) begin
         if (cfg_addr[15:0] == DMA_REG_ADDR) begin
            reg_start <= pkt_data(cfg_packet);
         end
         if (cfg_addr[15:0] == DMA_REG_COUNT) begin
            reg_count <= pkt_data(cfg_packet);
         end
      end
   end

   // ##########################################################################
   // Issue FSM
   // ##########################################################################

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state     <= IDLE;
         cur_addr  <= '0;
         remaining <= '0;
         issue_idx <= '0;
      end else begin
         case (state)
            IDLE: begin
               // Zero count leaves the engine idle
               if (go_hit && reg_count != '0) begin
                  cur_addr  <= reg_start;
                  remaining <= reg_count;
                  issue_idx <= '0;
                  state     <= ISSUE;
               end
            end
            ISSUE: begin
               // GO ignored here
               if (accept) begin
                  cur_addr  <= cur_addr + 32'd4;
                  remaining <= remaining - 1'b1;
                  issue_idx <= issue_idx + 1'b1;
                  if (remaining == 32'd1) begin
                     state <= IDLE;
                  end
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // Reply goes to our response group, offset = index * 4
   assign req_srcaddr = {LINK_ID, GROUP_RR, issue_idx[13:0], 2'b00};

   assign edma_access = (state == ISSUE);
   // write 0, datamode 2, ctrlmode 0, data 0
   assign edma_packet = {1'b0, 2'b10, 5'b00000, cur_addr, 32'h0, req_srcaddr};

endmodule

`default_nettype wire

/* hw/erx_core.sv */
`timescale 1ns/1ps
`default_nettype none

module erx_core import erx_pkg::*; #(
   parameter link_id_t LINK_ID    = 12'h800,
   parameter int       FIFO_DEPTH = 4
) (
   input  wire           clk,
   input  wire           arst_n,
   // Incoming link traffic
   input  wire           erx_access,
   input  emesh_packet_t erx_packet,
   output logic          rx_wr_wait,
   output logic          rx_rd_wait,
   // Register readback responses
   input  wire           ecfg_access,
   input  emesh_packet_t ecfg_packet,
   output logic          ecfg_wait,
   // Remote writes
   output logic          rxwr_access,
   output emesh_packet_t rxwr_packet,
   input  wire           rxwr_wait,
   // Read requests
   output logic          rxrd_access,
   output emesh_packet_t rxrd_packet,
   input  wire           rxrd_wait,
   // Read responses
   output logic          rxrr_access,
   output emesh_packet_t rxrr_packet,
   input  wire           rxrr_wait
);

   // ##########################################################################
   // Internal nets
   // ##########################################################################

   // Arbiter to buffers
   logic          wr_access;
   emesh_packet_t wr_packet;
   logic          wr_wait;
   logic          rd_access;
   emesh_packet_t rd_packet;
   logic          rd_wait;
   logic          rr_access;
   emesh_packet_t rr_packet;
   logic          rr_wait;

   // Engine links
   logic          edma_access;
   emesh_packet_t edma_packet;
   logic          edma_wait;
   logic          cfg_access;
   emesh_packet_t cfg_packet;

   // ##########################################################################
   // Steering
   // ##########################################################################

   erx_arbiter #(
      .LINK_ID (LINK_ID)
   ) u_arbiter (
      .erx_access  (erx_access),
      .erx_packet  (erx_packet),
      .rx_wr_wait  (rx_wr_wait),
      .rx_rd_wait  (rx_rd_wait),
      .ecfg_access (ecfg_access),
      .ecfg_packet (ecfg_packet),
      .ecfg_wait   (ecfg_wait),
      .edma_access (edma_access),
      .edma_packet (edma_packet),
      .edma_wait   (edma_wait),
      .wr_access   (wr_access),
      .wr_packet   (wr_packet),
      .wr_wait     (wr_wait),
      .rd_access   (rd_access),
      .rd_packet   (rd_packet),
      .rd_wait     (rd_wait),
      .rr_access   (rr_access),
      .rr_packet   (rr_packet),
      .rr_wait     (rr_wait),
      .cfg_access  (cfg_access),
      .cfg_packet  (cfg_packet)
   );

   // Read-request engine
   erx_dma #(
      .LINK_ID (LINK_ID)
   ) u_dma (
      .clk         (clk),
      .arst_n      (arst_n),
      .cfg_access  (cfg_access),
      .cfg_packet  (cfg_packet),
      .edma_access (edma_access),
      .edma_packet (edma_packet),
      .edma_wait   (edma_wait)
   );

   // ##########################################################################
   // Output buffers
   // ##########################################################################

   erx_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_wr_fifo (
      .clk        (clk),
      .arst_n     (arst_n),
      .in_access  (wr_access),
      .in_packet  (wr_packet),
      .in_wait    (wr_wait),
      .out_access (rxwr_access),
      .out_packet (rxwr_packet),
      .out_wait   (rxwr_wait)
   );

   erx_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_rd_fifo (
      .clk        (clk),
      .arst_n     (arst_n),
      .in_access  (rd_access),
      .in_packet  (rd_packet),
      .in_wait    (rd_wait),
      .out_access (rxrd_access),
      .out_packet (rxrd_packet),
      .out_wait   (rxrd_wait)
   );

   erx_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_rr_fifo (
      .clk        (clk),
      .arst_n     (arst_n),
      .in_access  (rr_access),
      .in_packet  (rr_packet),
      .in_wait    (rr_wait),
      .out_access (rxrr_access),
      .out_packet (rxrr_packet),
      .out_wait   (rxrr_wait)
   );

endmodule

`default_nettype wire

/* verif/erx_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module erx_assertions import erx_pkg::*; (
   input wire           clk,
   input wire           arst_n,
   input wire           erx_access,
   input emesh_packet_t erx_packet,
   input wire           edma_access,
   input emesh_packet_t edma_packet,
   input wire           rxwr_access,
   input emesh_packet_t rxwr_packet,
   input wire           rxwr_wait,
   input wire           rxrd_access,
   input emesh_packet_t rxrd_packet,
   input wire           rxrd_wait,
   input wire           rxrr_access,
   input emesh_packet_t rxrr_packet,
   input wire           rxrr_wait
);

   int unsigned fail_count = 0;

   // Held outputs keep access and head
   a_wr_hold: assert property (@(posedge clk) disable iff (!arst_n)
      (rxwr_access && rxwr_wait) |=> (rxwr_access && $stable(rxwr_packet)))
      else begin
         fail_count++;
         $error("write output changed while its wait was high");
      end

   a_rd_hold: assert property (@(posedge clk) disable iff (!arst_n)
      (rxrd_access && rxrd_wait) |=> (rxrd_access && $stable(rxrd_packet)))
      else begin
         fail_count++;
         $error("read output changed while its wait was high");
      end

   a_rr_hold: assert property (@(posedge clk) disable iff (!arst_n)
      (rxrr_access && rxrr_wait) |=> (rxrr_access && $stable(rxrr_packet)))
      else begin
         fail_count++;
         $error("response output changed while its wait was high");
      end

   // Quiet during reset
   a_reset_idle: assert property (@(posedge clk)
      !arst_n |-> (!rxwr_access && !rxrd_access && !rxrr_access && !edma_access))
      else begin
         fail_count++;
         $error("access high during reset");
      end

   // erx read wins, so the engine keeps its request in place
   a_read_prio: assert property (@(posedge clk) disable iff (!arst_n)
      (erx_access && !pkt_write(erx_packet) && edma_access)
      |=> (edma_access && $stable(edma_packet)))
      else begin
         fail_count++;
         $error("engine request accepted beside an erx read");
      end

endmodule

`default_nettype wire

/* verif/erx_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module erx_tb import erx_pkg::*; ();

   localparam link_id_t LINK_ID    = 12'h800;
   localparam link_id_t OTHER_ID   = 12'h123;
   localparam int       FIFO_DEPTH = 4;
   // About 105 packets with a few stalled cycles each under back-pressure
   // so a few thousand cycles at most
   localparam int unsigned TIMEOUT_CYCLES = 20000;

   typedef enum {PATH_WR, PATH_RD, PATH_RR, PATH_NONE} path_t;

   logic          clk;
   logic          arst_n;
   logic          erx_access;
   emesh_packet_t erx_packet;
   logic          rx_wr_wait;
   logic          rx_rd_wait;
   logic          ecfg_access;
   emesh_packet_t ecfg_packet;
   logic          ecfg_wait;
   logic          rxwr_access;
   emesh_packet_t rxwr_packet;
   logic          rxwr_wait;
   logic          rxrd_access;
   emesh_packet_t rxrd_packet;
   logic          rxrd_wait;
   logic          rxrr_access;
   emesh_packet_t rxrr_packet;
   logic          rxrr_wait;

   // Expected packets per stream with engine reads kept apart from erx reads
   emesh_packet_t wr_exp[$];
   emesh_packet_t rd_exp[$];
   emesh_packet_t dma_exp[$];
   emesh_packet_t rr_exp[$];

   logic [31:0] rng_state;
   logic [31:0] bp_state;
   logic        bp_on;
   bit          timeout_hit;
   int unsigned cycle_count;
   int unsigned mismatch_count;
   int unsigned other_count;
   string       test_name;

   always #2 clk = ~clk;

   erx_core #(
      .LINK_ID    (LINK_ID),
      .FIFO_DEPTH (FIFO_DEPTH)
   ) i_dut (.*);

   bind erx_core erx_assertions u_assertions (
      .clk         (clk),
      .arst_n      (arst_n),
      .erx_access  (erx_access),
      .erx_packet  (erx_packet),
      .edma_access (edma_access),
      .edma_packet (edma_packet),
      .rxwr_access (rxwr_access),
      .rxwr_packet (rxwr_packet),
      .rxwr_wait   (rxwr_wait),
      .rxrd_access (rxrd_access),
      .rxrd_packet (rxrd_packet),
      .rxrd_wait   (rxrd_wait),
      .rxrr_access (rxrr_access),
      .rxrr_packet (rxrr_packet),
      .rxrr_wait   (rxrr_wait)
   );

   // ##########################################################################
   // Random source and reference routing
   // ##########################################################################

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] rand32();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // Destination stream of one erx packet
   function automatic path_t route(input emesh_packet_t pkt);
      logic  write;
      addr_t dst;
      logic  own;
      write = pkt[103];
      dst   = pkt[95:64];
      own   = (dst[31:20] == LINK_ID);
      if (own && dst[19:16] == GROUP_RR) begin
         return PATH_RR;
      end else if (own && write) begin
         return PATH_NONE;
      end else if (write) begin
         return PATH_WR;
      end
      return PATH_RD;
   endfunction

   function automatic emesh_packet_t random_packet(input path_t kind);
      logic [31:0] r;
      logic [31:0] s;
      addr_t       dst;
      r = rand32();
      s = rand32();
      case (kind)
         PATH_RR:   dst = {LINK_ID, GROUP_RR, r[15:0]};
         // Own write that hits no engine register
         PATH_NONE: dst = {LINK_ID, GROUP_REG, 8'h01, r[7:2], 2'b00};
         default: begin
            dst = rand32();
            if (dst[31:20] == LINK_ID) begin
               dst[31:20] = OTHER_ID;
            end
         end
      endcase
      // Source id never matches the engine's reply group
      return {kind != PATH_RD, r[30:24], dst, rand32(), OTHER_ID, s[19:0]};
   endfunction

   // Register readback packet with random content
   function automatic emesh_packet_t random_response();
      logic [31:0] r;
      r = rand32();
      return {r[7:0], rand32(), rand32(), rand32()};
   endfunction

   // ##########################################################################
   // Drivers
   // ##########################################################################

   task automatic send_erx(input emesh_packet_t pkt, output int unsigned accept_cycle);
      logic stalled;
      @(negedge clk);
      erx_access = 1'b1;
      erx_packet = pkt;
      do begin
         @(posedge clk);
         // Writes stall on the write side and reads on the read side
         stalled = pkt[103] ? rx_wr_wait : rx_rd_wait;
      end while (stalled);
      accept_cycle = cycle_count;
      case (route(pkt))
         PATH_WR: wr_exp.push_back(pkt);
         PATH_RD: rd_exp.push_back(pkt);
         PATH_RR: rr_exp.push_back(pkt);
         default: ;
      endcase
   endtask

   task automatic send_ecfg(input emesh_packet_t pkt, output int unsigned accept_cycle);
      @(negedge clk);
      ecfg_access = 1'b1;
      ecfg_packet = pkt;
      do begin
         @(posedge clk);
      end while (ecfg_wait);
      accept_cycle = cycle_count;
      rr_exp.push_back(pkt);
   endtask

   task automatic erx_stop();
      @(negedge clk);
      erx_access = 1'b0;
   endtask

   task automatic write_reg(input logic [15:0] offset, input data_t data);
      int unsigned c;
      send_erx({1'b1, 7'h0, LINK_ID, GROUP_REG, offset, data, 32'h0}, c);
   endtask

   // Program the engine and expect count reads at start + 4k
   task automatic run_dma(input addr_t start, input data_t count);
      write_reg(DMA_REG_ADDR, start);
      write_reg(DMA_REG_COUNT, count);
      write_reg(DMA_REG_GO, 32'h1);
      for (int k = 0; k < count; k++) begin
         dma_exp.push_back({1'b0, 2'd2, 5'd0, start + 32'(4 * k), 32'h0,
                            LINK_ID, GROUP_RR, 16'(4 * k)});
      end
      erx_stop();
   endtask

   task automatic drain();
      while (wr_exp.size() + rd_exp.size() + dma_exp.size() + rr_exp.size() != 0) begin
         @(posedge clk);
      end
      // Room for any extra packet to show up
      repeat (10) @(posedge clk);
   endtask

   task automatic finish_run();
      int unsigned assert_count;
      assert_count = i_dut.u_assertions.fail_count;
      $display("Errors: %0d mismatches, %0d other, %0d assertions, %0d timeouts",
               mismatch_count, other_count, assert_count, timeout_hit);
      if (mismatch_count == 0 && other_count == 0 && assert_count == 0 && !timeout_hit) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   endtask

   // ##########################################################################
   // Scoreboard
   // ##########################################################################

   task automatic check_packet(input string stream, input emesh_packet_t exp,
                               input emesh_packet_t got);
      assert (got === exp) else begin
         mismatch_count++;
         $display("FAIL %s %s expected %h actual %h", test_name, stream, exp, got);
      end
   endtask

   task automatic report_extra(input string stream);
      other_count++;
      $display("ERROR: %s output delivered a packet that was never sent", stream);
   endtask

   always @(posedge clk) begin
      if (arst_n) begin
         if (rxwr_access && !rxwr_wait) begin
            assert (wr_exp.size() > 0) else report_extra("write");
            if (wr_exp.size() > 0) check_packet("write", wr_exp.pop_front(), rxwr_packet);
         end
         if (rxrd_access && !rxrd_wait) begin
            // Engine requests carry the reply group in srcaddr
            if (rxrd_packet[31:16] == {LINK_ID, GROUP_RR}) begin
               assert (dma_exp.size() > 0) else report_extra("engine read");
               if (dma_exp.size() > 0) begin
                  check_packet("engine read", dma_exp.pop_front(), rxrd_packet);
               end
            end else begin
               assert (rd_exp.size() > 0) else report_extra("read");
               if (rd_exp.size() > 0) check_packet("read", rd_exp.pop_front(), rxrd_packet);
            end
         end
         if (rxrr_access && !rxrr_wait) begin
            assert (rr_exp.size() > 0) else report_extra("response");
            if (rr_exp.size() > 0) check_packet("response", rr_exp.pop_front(), rxrr_packet);
         end
      end
   end

   // Random output back-pressure when enabled
   always @(negedge clk) begin
      bp_state  = xorshift32(bp_state);
      rxwr_wait = bp_on & bp_state[3];
      rxrd_wait = bp_on & bp_state[11];
      rxrr_wait = bp_on & bp_state[19];
   end

   always @(negedge clk) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         timeout_hit = 1'b1;
         $display("ERROR: run stopped after %0d cycles with packets still missing",
                  cycle_count);
         finish_run();
      end
   end

   // ##########################################################################
   // Test sequence
   // ##########################################################################

   initial begin
      int unsigned c_erx;
      int unsigned c_ecfg;
      int unsigned first_erx;
      int unsigned first_ecfg;
      path_t       kind;
      clk            = 1'b0;
      arst_n         = 1'b0;
      erx_access     = 1'b0;
      erx_packet     = '0;
      ecfg_access    = 1'b0;
      ecfg_packet    = '0;
      rxwr_wait      = 1'b0;
      rxrd_wait      = 1'b0;
      rxrr_wait      = 1'b0;
      bp_on          = 1'b0;
      rng_state      = 32'd94;
      bp_state       = xorshift32(32'd94);
      timeout_hit    = 1'b0;
      cycle_count    = 0;
      mismatch_count = 0;
      other_count    = 0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;

      test_name = "idle_after_reset";
      repeat (5) begin
         @(posedge clk);
         assert (!rxwr_access && !rxrd_access && !rxrr_access) else begin
            other_count++;
            $display("ERROR: an output access went high before any input was sent");
         end
      end

      test_name = "write_read_stream";
      for (int i = 0; i < 16; i++) begin
         kind = (rand32() % 2 == 0) ? PATH_WR : PATH_RD;
         send_erx(random_packet(kind), c_erx);
      end
      erx_stop();
      drain();

      // ecfg and erx responses offered in the same cycle
      test_name = "response_priority";
      fork
         begin
            for (int i = 0; i < 4; i++) begin
               send_ecfg(random_response(), c_ecfg);
               if (i == 0) first_ecfg = c_ecfg;
            end
            @(negedge clk);
            ecfg_access = 1'b0;
         end
         begin
            for (int i = 0; i < 4; i++) begin
               send_erx(random_packet(PATH_RR), c_erx);
               if (i == 0) first_erx = c_erx;
            end
            erx_stop();
         end
      join
      assert (first_ecfg < first_erx) else begin
         other_count++;
         $display("ERROR: erx response was accepted before the competing ecfg response");
      end
      drain();

      test_name = "dma_run";
      run_dma(32'h0030_0200, 32'd6);
      for (int i = 0; i < 11; i++) begin
         kind = (i % 4 == 3) ? PATH_NONE : PATH_RD;
         send_erx(random_packet(kind), c_erx);
      end
      erx_stop();
      drain();

      test_name = "back_pressure";
      bp_on = 1'b1;
      fork
         begin
            for (int i = 0; i < 10; i++) begin
               send_ecfg(random_response(), c_ecfg);
            end
            @(negedge clk);
            ecfg_access = 1'b0;
         end
         begin
            run_dma(32'h0040_1000, 32'd8);
            for (int i = 0; i < 40; i++) begin
               kind = path_t'(rand32() % 4);
               send_erx(random_packet(kind), c_erx);
            end
            erx_stop();
         end
      join
      drain();
      bp_on = 1'b0;

      finish_run();
   end

endmodule

`default_nettype wire

/* filelist.f */
hw/erx_pkg.sv
hw/erx_arbiter.sv
hw/erx_fifo.sv
hw/erx_dma.sv
hw/erx_core.sv
verif/erx_assertions.sv
verif/erx_tb.sv

/* Bender.yml */
package:
  name: erx

sources:
  # Design
  - files:
      - hw/erx_pkg.sv
      - hw/erx_arbiter.sv
      - hw/erx_fifo.sv
      - hw/erx_dma.sv
      - hw/erx_core.sv

  # Testbench
  - target: test
    files:
      - verif/erx_assertions.sv
      - verif/erx_tb.sv
